// ==== compile.f ====
+incdir+include
rtl/cpc_load_pkg.sv
rtl/cpc_mf2_pkg.sv
rtl/rom_loader.sv
rtl/boot_control.sv
rtl/mf2_shadow_decode.sv
rtl/mf2_control.sv
rtl/mf2_ram.sv
rtl/cpc_mf2_top.sv
testbench/tb_cpc_mf2.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns -f compile.f \
    --top-module tb_cpc_mf2 -Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
    exit 0
fi
exit 1

// ==== testbench/tb_cpc_mf2.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpc_defs.svh"

module tb_cpc_mf2;

    logic                         clk_48;
    logic                         reset;
    logic                         ioctl_download, ioctl_wr;
    logic [`CPC_IOCTL_AW-1:0]     ioctl_addr;
    logic [7:0]                   ioctl_dout;
    logic [7:0]                   ioctl_index;
    logic                         plus_valid;
    logic [15:0]                  cpu_addr;
    logic [7:0]                   cpu_dout;
    logic                         m1, mem_rd, mem_wr, iorq, wr, key_nmi;
    logic                         boot_wr;
    logic [`CPC_BOOT_AW-1:0]      boot_addr;
    logic [7:0]                   boot_data;
    logic [`CPC_ROM_MAP_BITS-1:0] rom_map;
    logic                         core_reset, rom_loaded, plus_mode;
    logic                         mf2_rom_en, mf2_ram_en;
    logic [7:0]                   mf2_dout;

    string       test_name;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int unsigned seed_init;

    cpc_mf2_top dut_i (.*);

    initial begin
        clk_48 = 1'b0;
        forever #4 clk_48 = ~clk_48;    // 8 ns period
    end

    // ------------------------------
    // Reporting
    task automatic report_mismatch(input string what, input logic [255:0] expected,
                                   input logic [255:0] actual);
        $display("error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        errors++;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %s done, no errors", test_name);
        end else begin
            tests_failed++;
            $display("test %s done, %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // ------------------------------
    // Inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk_48);
        #1;
    endtask

    // Slot to bank rule of the loader
    function automatic logic [8:0] slot_bank(input int slot);
        case (slot)
            0:       return 9'h000;     // OS
            1:       return 9'h100;     // BASIC
            2:       return 9'h107;     // AMSDOS
            default: return 9'h0ff;     // MF2
        endcase
    endfunction

    task automatic start_download(input logic [7:0] index);
        next_cycle();
        ioctl_index    = index;
        ioctl_download = 1'b1;
    endtask

    task automatic end_download();
        next_cycle();
        ioctl_download = 1'b0;
    endtask

    task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
        next_cycle();
        ioctl_addr = addr;
        ioctl_dout = data;
        ioctl_wr   = 1'b1;      // One-cycle strobe
        next_cycle();
        ioctl_wr   = 1'b0;
    endtask

    // Looks for boot_wr on falling edges for up to limit cycles
    task automatic wait_boot_write(input int limit, output logic found);
        int n;
        found = 1'b0;
        n     = 0;
        while (!found && n < limit) begin
            @(negedge clk_48);
            found = boot_wr;
            n++;
        end
    endtask

    task automatic drive_bus(input logic [15:0] addr, input logic [7:0] data, input logic fetch,
                             input logic rd, input logic mwr, input logic iowr);
        next_cycle();
        cpu_addr = addr;
        cpu_dout = data;
        m1       = fetch;
        mem_rd   = rd;
        mem_wr   = mwr;
        iorq     = iowr;
        wr       = iowr;
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        drive_bus(addr, data, 1'b0, 1'b0, 1'b0, 1'b1);
        drive_bus(addr, data, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
        drive_bus(addr, data, 1'b0, 1'b0, 1'b1, 1'b0);
        drive_bus(addr, data, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic m1_fetch(input logic [15:0] addr);
        drive_bus(addr, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0);
        drive_bus(addr, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic press_nmi();
        next_cycle();
        key_nmi = 1'b1;
        next_cycle();
        key_nmi = 1'b0;
    endtask

    // Window enables for an address sampled mid-cycle
    task automatic probe(input logic [15:0] addr, output logic rom_en, output logic ram_en);
        drive_bus(addr, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
        @(negedge clk_48);
        rom_en = mf2_rom_en;
        ram_en = mf2_ram_en;
    endtask

    // Read data lands 2 cycles after the address
    task automatic read_byte(input logic [15:0] addr, output logic [7:0] dout);
        drive_bus(addr, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0);
        repeat (2) @(posedge clk_48);
        @(negedge clk_48);
        dout = mf2_dout;
    endtask

    // ------------------------------
    // Tests
    task automatic boot_release_test();
        logic released;
        int   n;
        begin_test("boot_release");
        @(negedge clk_48);
        if (core_reset !== 1'b1)
            report_mismatch("core_reset after reset", 256'(1), 256'(core_reset));
        if (rom_loaded !== 1'b0)
            report_mismatch("rom_loaded after reset", 256'(0), 256'(rom_loaded));
        start_download(8'd0);
        repeat (3) next_cycle();
        @(negedge clk_48);
        if (core_reset !== 1'b1) report_failure("core_reset released during a ROM download");
        end_download();
        released = 1'b0;
        n        = 0;
        while (!released && n < 3) begin
            @(negedge clk_48);
            released = !core_reset;
            n++;
        end
        if (!released) begin
            report_failure("core_reset still high after the download ended");
        end else begin
            if (rom_loaded !== 1'b1) report_mismatch("rom_loaded", 256'(1), 256'(rom_loaded));
            if (plus_mode !== 1'b0) report_mismatch("plus_mode", 256'(0), 256'(plus_mode));
        end
        // Cartridge download from a fresh reset, core runs as it streams in
        next_cycle();
        reset      = 1'b1;
        plus_valid = 1'b1;
        repeat (2) next_cycle();
        reset = 1'b0;
        start_download(8'd5);
        released = 1'b0;
        n        = 0;
        while (!released && n < 3) begin
            @(negedge clk_48);
            released = !core_reset;
            n++;
        end
        if (!released) report_failure("core_reset still high after a plus download began");
        end_download();
        n = 0;
        while (!plus_mode && n < 3) begin
            @(negedge clk_48);
            n++;
        end
        if (!plus_mode) report_failure("plus_mode not set after a plus download");
        end_test();
    endtask

    task automatic rom_remap_test();
        logic [13:0] offset;
        logic [7:0]  data;
        logic [22:0] expected;
        logic        found;
        int          slot;
        int          k;
        begin_test("rom_remap");
        start_download(8'd0);
        for (slot = 0; slot < 5; slot++) begin
            for (k = 0; k < 2; k++) begin
                offset = (k == 0) ? 14'h0000 : 14'h3fff;   // Both ends of a 16 KB slot
                data   = 8'($urandom);
                send_byte({11'(slot), offset}, data);
                wait_boot_write(4, found);
                if (slot == 4) begin
                    if (found) report_failure("boot write for a byte in slot 4");
                end else if (!found) begin
                    report_failure($sformatf("no boot write for a byte in slot %0d", slot));
                end else begin
                    expected = {slot_bank(slot), offset};
                    if (boot_addr != expected) begin
                        report_mismatch("boot_addr", 256'(expected), 256'(boot_addr));
                    end
                    if (boot_data != data) begin
                        report_mismatch("boot_data", 256'(data), 256'(boot_data));
                    end
                    @(negedge clk_48);
                    if (boot_wr) report_failure("boot_wr high for more than one cycle");
                end
            end
        end
        end_download();
        start_download(8'd4);                           // Loader stays quiet for tape
        send_byte(25'h0000010, 8'($urandom));
        wait_boot_write(4, found);
        if (found) report_failure("boot write during a tape download");
        end_download();
        end_test();
    endtask

    task automatic rom_map_test();
        logic [255:0] expected;
        begin_test("rom_map");
        expected    = '0;
        expected[0] = 1'b1;     // OS and BASIC
        expected[7] = 1'b1;     // AMSDOS
        @(negedge clk_48);
        if (rom_map != expected) report_mismatch("rom_map", expected, rom_map);
        end_test();
    endtask

    task automatic nmi_paging_test();
        logic rom_en, ram_en;
        int   n;
        begin_test("nmi_paging");
        press_nmi();
        m1_fetch(16'h0066);
        rom_en = 1'b0;
        n      = 0;
        while (!rom_en && n < 4) begin
            probe(16'h0100, rom_en, ram_en);
            n++;
        end
        if (!rom_en) report_failure("MF2 ROM not paged in after the NMI fetch");
        probe(16'h2100, rom_en, ram_en);
        if (ram_en !== 1'b1) report_mismatch("mf2_ram_en at 2100", 256'(1), 256'(ram_en));
        if (rom_en !== 1'b0) report_mismatch("mf2_rom_en at 2100", 256'(0), 256'(rom_en));
        io_write(16'hfeea, 8'h00);                      // Page out
        probe(16'h0100, rom_en, ram_en);
        if (rom_en !== 1'b0) report_mismatch("mf2_rom_en after feea", 256'(0), 256'(rom_en));
        probe(16'h2100, rom_en, ram_en);
        if (ram_en !== 1'b0) report_mismatch("mf2_ram_en after feea", 256'(0), 256'(ram_en));
        io_write(16'hfee8, 8'h00);                      // Page back in
        probe(16'h0100, rom_en, ram_en);
        if (rom_en !== 1'b1) report_mismatch("mf2_rom_en after fee8", 256'(1), 256'(rom_en));
        probe(16'h2100, rom_en, ram_en);
        if (ram_en !== 1'b1) report_mismatch("mf2_ram_en after fee8", 256'(1), 256'(ram_en));
        end_test();
    endtask

    task automatic shadow_ram_test();
        logic [7:0] crtc_val, mem_val, dout;
        begin_test("shadow_ram");
        crtc_val = 8'($urandom);
        mem_val  = 8'($urandom);
        io_write(16'hfeea, 8'h00);                      // Hardware writes while paged out
        io_write(16'hbc00, 8'h05);                      // Selects CRTC register 5
        io_write(16'hbd00, crtc_val);
        io_write(16'hfee8, 8'h00);
        read_byte(16'h3cff, dout);
        if (dout !== 8'h05) report_mismatch("read at 3cff", 256'(8'h05), 256'(dout));
        read_byte(16'h3db5, dout);
        if (dout !== crtc_val) report_mismatch("read at 3db5", 256'(crtc_val), 256'(dout));
        mem_write(16'h2010, mem_val);
        read_byte(16'h2010, dout);
        if (dout !== mem_val) report_mismatch("read at 2010", 256'(mem_val), 256'(dout));
        io_write(16'hfeea, 8'h00);
        read_byte(16'h3cff, dout);                      // Idle bus while paged out
        if (dout !== 8'hff) report_mismatch("mf2_dout paged out", 256'(8'hff), 256'(dout));
        end_test();
    endtask

    task automatic hide_test();
        logic rom_en, ram_en;
        begin_test("hide");
        io_write(16'hfee8, 8'h00);
        m1_fetch(16'h0065);
        probe(16'h0100, rom_en, ram_en);                // Hidden but still paged
        if (rom_en !== 1'b1) report_mismatch("mf2_rom_en after 0065", 256'(1), 256'(rom_en));
        io_write(16'hfeea, 8'h00);
        io_write(16'hfee8, 8'h00);                      // Must not page back in
        probe(16'h0100, rom_en, ram_en);
        if (rom_en !== 1'b0) report_mismatch("mf2_rom_en once hidden", 256'(0), 256'(rom_en));
        end_test();
    endtask

    // ------------------------------
    initial begin
        seed_init      = $urandom(3);
        errors         = 0;
        errors_at_start = 0;
        tests_run      = 0;
        tests_failed   = 0;
        reset          = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = 8'h00;
        ioctl_index    = 8'h00;
        plus_valid     = 1'b0;
        cpu_addr       = 16'h0000;
        cpu_dout       = 8'h00;
        m1             = 1'b0;
        mem_rd         = 1'b0;
        mem_wr         = 1'b0;
        iorq           = 1'b0;
        wr             = 1'b0;
        key_nmi        = 1'b0;
        repeat (2) @(posedge clk_48);
        #1;
        reset = 1'b0;

        boot_release_test();    // MF2 stays in reset until a download ends
        rom_remap_test();
        rom_map_test();
        nmi_paging_test();
        shadow_ram_test();
        hide_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/cpc_mf2_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpc_defs.svh"

module cpc_mf2_top (
    input  logic                     clk_48,
    input  logic                     reset,
    // Download port
    input  logic                     ioctl_download,
    input  logic                     ioctl_wr,
    input  logic [`CPC_IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]               ioctl_dout,
    input  logic [7:0]               ioctl_index,
    input  logic                     plus_valid,
    // CPU bus
    input  logic [15:0]              cpu_addr,
    input  logic [7:0]               cpu_dout,
    input  logic                     m1,
    input  logic                     mem_rd,
    input  logic                     mem_wr,
    input  logic                     iorq,
    input  logic                     wr,
    input  logic                     key_nmi,
    // Boot memory and status
    output logic                     boot_wr,
    output cpc_load_pkg::boot_addr_t boot_addr,
    output logic [7:0]               boot_data,
    output cpc_load_pkg::rom_map_t   rom_map,
    output logic                     core_reset,
    output logic                     rom_loaded,
    output logic                     plus_mode,
    // Multiface Two
    output logic                     mf2_rom_en,
    output logic                     mf2_ram_en,
    output logic [7:0]               mf2_dout
);

    import cpc_mf2_pkg::*;

    hw_port_e   shadow_port;
    mf2_addr_t  shadow_addr;
    logic       io_wr_rise;
    mf2_addr_t  ram_addr;
    logic [7:0] ram_wdata;
    logic       ram_we;
    logic [7:0] ram_rdata;

    // ------------------------------
    // Loader and boot
    rom_loader u_rom_loader (
        .clk_48(clk_48), .reset(reset),
        .ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_index(ioctl_index),
        .boot_wr(boot_wr), .boot_addr(boot_addr), .boot_data(boot_data),
        .rom_map(rom_map)
    );

    boot_control u_boot_control (
        .clk_48(clk_48), .reset(reset),
        .ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
        .plus_valid(plus_valid),
        .core_reset(core_reset), .rom_loaded(rom_loaded), .plus_mode(plus_mode)
    );

    // ------------------------------
    // Multiface Two
    mf2_shadow_decode u_shadow (
        .clk_48(clk_48), .reset(reset),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .io_wr_rise(io_wr_rise),
        .shadow_port(shadow_port), .shadow_addr(shadow_addr)
    );

    mf2_control u_mf2_control (
        .clk_48(clk_48), .core_reset(core_reset),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .m1(m1), .mem_wr(mem_wr), .iorq(iorq), .wr(wr), .key_nmi(key_nmi),
        .shadow_port(shadow_port), .shadow_addr(shadow_addr),
        .io_wr_rise(io_wr_rise), .mf2_rom_en(mf2_rom_en), .mf2_ram_en(mf2_ram_en),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we)
    );

    mf2_ram u_mf2_ram (
        .clk_48(clk_48),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
        .ram_rdata(ram_rdata)
    );

    // Bus is ANDed with other sources upstream, so idle is all ones
    assign mf2_dout = (mf2_ram_en && mem_rd) ? ram_rdata : 8'hff;

endmodule

`default_nettype wire

// ==== rtl/mf2_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpc_defs.svh"

module mf2_ram (
    input  logic                   clk_48,
    input  cpc_mf2_pkg::mf2_addr_t ram_addr,
    input  logic [7:0]             ram_wdata,
    input  logic                   ram_we,
    output logic [7:0]             ram_rdata
);

    localparam int DEPTH = 1 << `CPC_MF2_AW;   // 8 KB

    logic [7:0] mem [0:DEPTH-1];

    // Registered read, written byte appears on the output
    always_ff @(posedge clk_48) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
            ram_rdata     <= ram_wdata;
        end else begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mf2_control.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpc_defs.svh"

module mf2_control (
    input  logic                   clk_48,
    input  logic                   core_reset,
    input  logic [15:0]            cpu_addr,
    input  logic [7:0]             cpu_dout,
    input  logic                   m1,
    input  logic                   mem_wr,
    input  logic                   iorq,
    input  logic                   wr,
    input  logic                   key_nmi,
    input  cpc_mf2_pkg::hw_port_e  shadow_port,
    input  cpc_mf2_pkg::mf2_addr_t shadow_addr,
    output logic                   io_wr_rise,
    output logic                   mf2_rom_en,
    output logic                   mf2_ram_en,
    output cpc_mf2_pkg::mf2_addr_t ram_addr,
    output logic [7:0]             ram_wdata,
    output logic                   ram_we
);

    import cpc_mf2_pkg::*;

    mf2_state_e state;
    logic       io_wr;
    logic       io_wr_q, m1_q, nmi_q;
    logic       m1_rise, nmi_rise;
    logic       ctrl_hit;       // Write to fee8 or feea
    logic       paged;

    assign io_wr      = wr && iorq;
    assign io_wr_rise = io_wr && !io_wr_q;
    assign m1_rise    = m1 && !m1_q;
    assign nmi_rise   = key_nmi && !nmi_q;
    assign ctrl_hit   = io_wr_rise && (cpu_addr[15:2] == `CPC_MF2_CTRL_PORT);

    assign paged      = (state == MF2_PAGED) || (state == MF2_PAGED_HIDDEN);
    assign mf2_rom_en = paged && (cpu_addr[15:13] == 3'b000);  // 0000-1fff
    assign mf2_ram_en = paged && (cpu_addr[15:13] == 3'b001);  // 2000-3fff

    always_ff @(posedge clk_48) begin
        if (core_reset) begin
            io_wr_q <= 1'b0;
            m1_q    <= 1'b0;
            nmi_q   <= 1'b0;
        end else begin
            io_wr_q <= io_wr;
            m1_q    <= m1;
            nmi_q   <= key_nmi;
        end
    end

    // ------------------------------
    // Paging FSM
    always_ff @(posedge clk_48) begin
        if (core_reset) begin
            state <= MF2_OFF;
        end else if (ctrl_hit) begin
            if (state == MF2_PAGED_HIDDEN || state == MF2_HIDDEN)
                state <= MF2_HIDDEN;            // Ports only page out once hidden
            else
                state <= cpu_addr[1] ? MF2_OFF : MF2_PAGED;
        end else begin
            case (state)
                MF2_OFF, MF2_HIDDEN:
                    if (nmi_rise) state <= MF2_NMI_PENDING;
                MF2_NMI_PENDING:
                    if (m1_rise && cpu_addr == `CPC_MF2_NMI_VEC) state <= MF2_PAGED;
                MF2_PAGED:
                    if (m1_rise && cpu_addr == `CPC_MF2_HIDE_ADDR) state <= MF2_PAGED_HIDDEN;
                MF2_PAGED_HIDDEN: state <= MF2_PAGED_HIDDEN;
                default:          state <= MF2_OFF;
            endcase
        end
    end

    // ------------------------------
    // One RAM port request per cycle
    always_ff @(posedge clk_48) begin
        if (core_reset)
            ram_we <= 1'b0;
        else
            ram_we <= !ctrl_hit && ((io_wr_rise && shadow_port != PORT_NONE)
                                    || (mem_wr && mf2_ram_en));
    end

    always_ff @(posedge clk_48) begin
        if (!ctrl_hit) begin
            ram_wdata <= cpu_dout;              // Port data or CPU write data
            if (io_wr_rise && shadow_port != PORT_NONE)
                ram_addr <= shadow_addr;        // Shadow store of a hardware write
            else
                ram_addr <= cpu_addr[12:0];     // CPU access in the RAM window
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mf2_shadow_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpc_defs.svh"

module mf2_shadow_decode (
    input  logic                   clk_48,
    input  logic                   reset,
    input  logic [15:0]            cpu_addr,
    input  logic [7:0]             cpu_dout,
    input  logic                   io_wr_rise,
    output cpc_mf2_pkg::hw_port_e  shadow_port,
    output cpc_mf2_pkg::mf2_addr_t shadow_addr
);

    import cpc_mf2_pkg::*;

    logic [4:0] pen_index;      // Gate array pen, bit 4 selects border
    logic [3:0] crtc_reg;       // Selected CRTC register

    // ------------------------------
    // Port decode
    always_comb begin
        shadow_port = PORT_NONE;
        case (cpu_addr[15:8])
            `CPC_PORT_GA: begin
                case (cpu_dout[7:6])    // Gate array function bits
                    2'b00:   shadow_port = PORT_GA_PEN;
                    2'b01:   shadow_port = PORT_GA_COLOUR;
                    2'b10:   shadow_port = PORT_GA_MODE;
                    default: shadow_port = PORT_GA_BANK;
                endcase
            end
            `CPC_PORT_CRTC_SEL:  shadow_port = PORT_CRTC_SEL;
            `CPC_PORT_CRTC_DATA: shadow_port = PORT_CRTC_DATA;
            `CPC_PORT_PPI:       shadow_port = PORT_PPI;
            `CPC_PORT_ROM_SEL:   shadow_port = PORT_ROM_SEL;
            default:             shadow_port = PORT_NONE;
        endcase
    end

    // Shadow location per port
    always_comb begin
        case (shadow_port)
            PORT_GA_PEN:    shadow_addr = `CPC_SHADOW_PEN;
            PORT_GA_COLOUR: shadow_addr = pen_index[4] ? `CPC_SHADOW_BORDER
                                                      : {`CPC_SHADOW_PALETTE, pen_index[3:0]};
            PORT_GA_MODE:   shadow_addr = `CPC_SHADOW_MODE;
            PORT_GA_BANK:   shadow_addr = `CPC_SHADOW_BANKING;
            PORT_CRTC_SEL:  shadow_addr = `CPC_SHADOW_CRTC_SEL;
            PORT_CRTC_DATA: shadow_addr = {`CPC_SHADOW_CRTC_DATA, crtc_reg};
            PORT_PPI:       shadow_addr = `CPC_SHADOW_PPI;
            PORT_ROM_SEL:   shadow_addr = `CPC_SHADOW_ROM_SEL;
            default:        shadow_addr = '0;
        endcase
    end

    // ------------------------------
    // Index registers, later colour and CRTC data writes depend on them
    always_ff @(posedge clk_48) begin
        if (reset) begin
            pen_index <= '0;
            crtc_reg  <= '0;
        end else if (io_wr_rise) begin
            if (shadow_port == PORT_GA_PEN)
                pen_index <= cpu_dout[4:0];
            if (shadow_port == PORT_CRTC_SEL)
                crtc_reg <= cpu_dout[3:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/boot_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module boot_control (
    input  logic       clk_48,
    input  logic       reset,
    input  logic       ioctl_download,
    input  logic [7:0] ioctl_index,
    input  logic       plus_valid,
    output logic       core_reset,
    output logic       rom_loaded,
    output logic       plus_mode
);

    import cpc_load_pkg::*;

    logic           download_q;     // Previous ioctl_download
    logic           dl_start;
    logic           dl_end;
    download_kind_e kind_now;
    download_kind_e kind_q;         // Class of the current transfer

    assign kind_now = decode_download(ioctl_index);
    assign dl_start = ioctl_download && !download_q;
    assign dl_end   = download_q && !ioctl_download;

    always_ff @(posedge clk_48) begin
        if (reset) begin
            download_q <= 1'b0;
            kind_q     <= DL_OTHER;
            core_reset <= 1'b1;     // Held until something is loaded
            rom_loaded <= 1'b0;
            plus_mode  <= 1'b0;
        end else begin
            download_q <= ioctl_download;
            if (dl_start) begin
                kind_q <= kind_now;
                if (kind_now == DL_PLUS)
                    core_reset <= 1'b0;     // Cartridge runs while it streams in
            end
            if (dl_end) begin
                core_reset <= 1'b0;
                rom_loaded <= 1'b1;
                if (kind_q == DL_PLUS && plus_valid)
                    plus_mode <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rom_loader.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpc_defs.svh"

module rom_loader (
    input  logic                       clk_48,
    input  logic                       reset,
    input  logic                       ioctl_download,
    input  logic                       ioctl_wr,
    input  logic [`CPC_IOCTL_AW-1:0]   ioctl_addr,
    input  logic [7:0]                 ioctl_dout,
    input  logic [7:0]                 ioctl_index,
    output logic                       boot_wr,
    output cpc_load_pkg::boot_addr_t   boot_addr,
    output logic [7:0]                 boot_data,
    output cpc_load_pkg::rom_map_t     rom_map
);

    import cpc_load_pkg::*;

    download_kind_e             kind;
    logic [10:0]                slot;       // 16 KB slot within the image
    logic                       accept;
    logic [`CPC_ROM_BANK_W-1:0] bank;

    assign kind   = decode_download(ioctl_index);
    assign slot   = ioctl_addr[24:14];
    assign accept = ioctl_download && ioctl_wr && (kind == DL_ROM) && (slot < 11'd4);

    // Slot to boot bank
    always_comb begin
        case (slot[1:0])
            2'd0:    bank = `CPC_BANK_OS;
            2'd1:    bank = `CPC_BANK_BASIC;
            2'd2:    bank = `CPC_BANK_AMSDOS;
            default: bank = `CPC_BANK_MF2;
        endcase
    end

    // ------------------------------
    // Boot write strobe, one cycle per byte
    always_ff @(posedge clk_48) begin
        if (reset) begin
            boot_wr <= 1'b0;
        end else begin
            boot_wr <= accept;
        end
    end

    always_ff @(posedge clk_48) begin
        if (accept) begin
            boot_addr <= {bank, ioctl_addr[13:0]};
            boot_data <= ioctl_dout;
        end
    end

    // ------------------------------
    // Upper ROM map
    always_ff @(posedge clk_48) begin
        if (reset) begin
            rom_map <= '0;
        end else if (boot_wr) begin
            if (boot_addr[22])                      // Upper ROM bank
                rom_map[boot_addr[21:14]] <= 1'b1;
            else if (boot_addr[22:14] == `CPC_BANK_OS)
                rom_map[0] <= 1'b1;                 // OS also counts as slot 0
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cpc_mf2_pkg.sv ====
`default_nettype none

`include "cpc_defs.svh"

package cpc_mf2_pkg;

    // Paging state of the Multiface Two
    typedef enum logic [2:0] {
        MF2_OFF          = 3'd0,
        MF2_NMI_PENDING  = 3'd1,    // Button pressed, waiting for the 0x66 fetch
        MF2_PAGED        = 3'd2,
        MF2_PAGED_HIDDEN = 3'd3,    // Still paged, ports no longer page in
        MF2_HIDDEN       = 3'd4
    } mf2_state_e;

    // Hardware register written by an I/O cycle
    typedef enum logic [3:0] {
        PORT_NONE      = 4'd0,
        PORT_GA_PEN    = 4'd1,
        PORT_GA_COLOUR = 4'd2,
        PORT_GA_MODE   = 4'd3,
        PORT_GA_BANK   = 4'd4,
        PORT_CRTC_SEL  = 4'd5,
        PORT_CRTC_DATA = 4'd6,
        PORT_PPI       = 4'd7,
        PORT_ROM_SEL   = 4'd8
    } hw_port_e;

    typedef logic [`CPC_MF2_AW-1:0] mf2_addr_t;

endpackage

`default_nettype wire

// ==== rtl/cpc_load_pkg.sv ====
`default_nettype none

`include "cpc_defs.svh"

package cpc_load_pkg;

    // Class of an ioctl transfer, from its index
    typedef enum logic [1:0] {
        DL_ROM   = 2'd0,
        DL_TAPE  = 2'd1,
        DL_PLUS  = 2'd2,    // CPR or BIN cartridge
        DL_OTHER = 2'd3
    } download_kind_e;

    typedef logic [`CPC_BOOT_AW-1:0]      boot_addr_t;
    typedef logic [`CPC_ROM_MAP_BITS-1:0] rom_map_t;

    // Index to download class
    function automatic download_kind_e decode_download(input logic [7:0] index);
        if (index < 8'd4)
            return DL_ROM;
        else if (index == 8'd4)
            return DL_TAPE;
        else if (index == 8'd5 || index == 8'd6)
            return DL_PLUS;
        else
            return DL_OTHER;
    endfunction

endpackage

`default_nettype wire

// ==== include/cpc_defs.svh ====
`ifndef CPC_DEFS_SVH
`define CPC_DEFS_SVH

// ------------------------------
// Widths
`define CPC_IOCTL_AW        25
`define CPC_BOOT_AW         23
`define CPC_ROM_BANK_W      9
`define CPC_ROM_MAP_BITS    256
`define CPC_MF2_AW          13

// ------------------------------
// Boot memory banks, 16 KB each
`define CPC_BANK_OS         9'h000
`define CPC_BANK_BASIC      9'h100
`define CPC_BANK_AMSDOS     9'h107
`define CPC_BANK_MF2        9'h0ff

// Multiface Two fetch addresses and paging ports
`define CPC_MF2_NMI_VEC     16'h0066
`define CPC_MF2_HIDE_ADDR   16'h0065
`define CPC_MF2_CTRL_PORT   14'h3fba    // fee8 / feea with a[1] selecting out

// CPC I/O port high bytes
`define CPC_PORT_GA         8'h7f
`define CPC_PORT_CRTC_SEL   8'hbc
`define CPC_PORT_CRTC_DATA  8'hbd
`define CPC_PORT_PPI        8'hf7
`define CPC_PORT_ROM_SEL    8'hdf

// ------------------------------
// Shadow locations in MF2 RAM
`define CPC_SHADOW_PEN        13'h1fcf
`define CPC_SHADOW_BORDER     13'h1fdf
`define CPC_SHADOW_PALETTE    9'h1f9    // Plus pen number in low nibble
`define CPC_SHADOW_MODE       13'h1fef
`define CPC_SHADOW_BANKING    13'h1fff
`define CPC_SHADOW_CRTC_SEL   13'h1cff
`define CPC_SHADOW_CRTC_DATA  9'h1db    // Plus CRTC register number
`define CPC_SHADOW_PPI        13'h17ff
`define CPC_SHADOW_ROM_SEL    13'h1aac

`endif
